// File: logic/policy_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Topic policy shared definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package policy_pkg;

	localparam int pio_nbits   = 32;	// Host bus data and address width
	localparam int mem_sel_bit = 15;	// Set for table region, clear for registers

	// Register region byte offsets
	localparam logic [pio_nbits-1:0] reg_id_addr   = 32'h0000_0000;
	localparam logic [pio_nbits-1:0] reg_ctrl_addr = 32'h0000_0004;
	localparam logic [pio_nbits-1:0] reg_deny_addr = 32'h0000_0008;

	localparam logic [pio_nbits-1:0] block_id = 32'h504F_4C31;	// "POL1"

	// Default table geometry
	localparam int def_depth_nbits = 6;
	localparam int def_item_nbits  = 16;
	localparam int role_count      = 4;	// Fixed, bank decode uses two address bits
	localparam int role_nbits      = $clog2(role_count);

	typedef enum logic [1:0] {
		PIO_IDLE,
		PIO_MEM_ISSUE,
		PIO_MEM_WAIT,
		PIO_ACK
	} pio_state_t;

	// Op value doubles as the permission bit index inside a role item
	typedef enum logic {
		OP_PUBLISH   = 1'b0,
		OP_SUBSCRIBE = 1'b1
	} policy_op_t;

endpackage

// File: logic/pio_bank.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Policy table bank
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pio_bank #(
	parameter int item_nbits  = 16,
	parameter int depth_nbits = 6
) (
	input  logic                               clk,
	input  logic                               rst_n,

	// Host port
	input  logic [depth_nbits-1:0]             reg_row,
	input  logic [policy_pkg::pio_nbits-1:0]   reg_din,
	input  logic                               reg_rd,
	input  logic                               reg_wr,
	input  logic                               reg_ms,
	output logic                               mem_ack,
	output logic [policy_pkg::pio_nbits-1:0]   mem_rdata,

	// Application read port
	input  logic                               app_mem_rd,
	input  logic [depth_nbits-1:0]             app_mem_raddr,
	output logic                               app_mem_ack,
	output logic [item_nbits-1:0]              app_mem_rdata
);

	localparam int pad_nbits = policy_pkg::pio_nbits - item_nbits;

	logic [item_nbits-1:0] mem [0:(1<<depth_nbits)-1];

	logic host_rd;
	logic host_wr;

	assign host_rd = reg_ms && reg_rd;
	assign host_wr = reg_ms && reg_wr;

	// Same-row read during a host write sees the old item
	always_ff @(posedge clk) begin
		if (host_wr)
			mem[reg_row] <= reg_din[item_nbits-1:0];	// Low bits only
		if (host_rd)
			mem_rdata <= {{pad_nbits{1'b0}}, mem[reg_row]};	// Zero-extended
		if (app_mem_rd)
			app_mem_rdata <= mem[app_mem_raddr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ack     <= 1'b0;
			app_mem_ack <= 1'b0;
		end else begin
			mem_ack     <= host_rd || host_wr;	// Writes are acked too
			app_mem_ack <= app_mem_rd;
		end
	end

endmodule

// File: logic/topic_policy_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interleaved topic policy memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module topic_policy_mem #(
	parameter int depth_nbits = 6,
	parameter int item_nbits  = 16
) (
	input  logic                                          clk,
	input  logic                                          rst_n,

	// Host side from the controller
	input  logic [policy_pkg::pio_nbits-1:0]              mem_addr,
	input  logic [policy_pkg::pio_nbits-1:0]              mem_din,
	input  logic                                          mem_rd,
	input  logic                                          mem_wr,
	input  logic                                          mem_sel,
	output logic                                          mem_ack,
	output logic [policy_pkg::pio_nbits-1:0]              mem_rdata,

	// Lookup side
	input  logic                                          topic_policy_rd,
	input  logic [depth_nbits-1:0]                        topic_policy_raddr,
	output logic                                          topic_policy_ack,
	output logic [item_nbits*policy_pkg::role_count-1:0]  topic_policy_rdata
);

	localparam int banks = policy_pkg::role_count;

	logic [policy_pkg::role_nbits-1:0] bank;
	logic [policy_pkg::role_nbits-1:0] bank_q;
	logic [depth_nbits-1:0]            row;
	logic [banks-1:0]                  bank_ms;
	logic [banks-1:0]                  bank_ack;
	logic [banks-1:0]                  app_ack;
	logic [policy_pkg::pio_nbits-1:0]  bank_rdata [banks];

	assign bank = mem_addr[3:2];	// Dword index bits 1:0
	assign row  = mem_addr[4 +: depth_nbits];

	always_comb begin
		for (int b = 0; b < banks; b++)
			bank_ms[b] = mem_sel && (bank == b[policy_pkg::role_nbits-1:0]);
	end

	// Bank index follows the strobe so the ack cycle picks the right bank
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bank_q <= '0;
		else if (mem_sel && (mem_rd || mem_wr))
			bank_q <= bank;
	end

	assign mem_ack   = bank_ack[bank_q];
	assign mem_rdata = bank_rdata[bank_q];

	assign topic_policy_ack = app_ack[0];	// All banks ack together

	for (genvar g = 0; g < banks; g++) begin : g_bank
		pio_bank #(
			.item_nbits  (item_nbits),
			.depth_nbits (depth_nbits)
		) u_pio_bank (
			.clk           (clk),
			.rst_n         (rst_n),
			.reg_row       (row),
			.reg_din       (mem_din),
			.reg_rd        (mem_rd),
			.reg_wr        (mem_wr),
			.reg_ms        (bank_ms[g]),
			.mem_ack       (bank_ack[g]),
			.mem_rdata     (bank_rdata[g]),
			.app_mem_rd    (topic_policy_rd),
			.app_mem_raddr (topic_policy_raddr),
			.app_mem_ack   (app_ack[g]),
			.app_mem_rdata (topic_policy_rdata[g*item_nbits +: item_nbits])
		);
	end

endmodule

// File: logic/pio_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO controller and registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pio_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,

	// Host bus
	input  logic [policy_pkg::pio_nbits-1:0]  reg_addr,
	input  logic [policy_pkg::pio_nbits-1:0]  reg_din,
	input  logic                              reg_rd,
	input  logic                              reg_wr,
	output logic                              reg_ack,
	output logic [policy_pkg::pio_nbits-1:0]  reg_rdata,

	// Table memory
	output logic [policy_pkg::pio_nbits-1:0]  mem_addr,
	output logic [policy_pkg::pio_nbits-1:0]  mem_din,
	output logic                              mem_rd,
	output logic                              mem_wr,
	output logic                              mem_sel,
	input  logic                              mem_ack,
	input  logic [policy_pkg::pio_nbits-1:0]  mem_rdata,

	// Lookup
	input  logic                              lookup_denied,
	output logic                              lookup_enable
);

	localparam int dw  = policy_pkg::pio_nbits;
	localparam int sel = policy_pkg::mem_sel_bit;

	policy_pkg::pio_state_t state;

	logic [dw-1:0] addr_q;
	logic [dw-1:0] din_q;
	logic [dw-1:0] rdata_q;
	logic          wr_q;
	logic          ctrl_en;
	logic [dw-1:0] deny_cnt;
	logic [dw-1:0] reg_off;
	logic [dw-1:0] reg_rval;
	logic          strobe;
	logic          reg_hit;
	logic          deny_clr;

	assign strobe   = (state == policy_pkg::PIO_IDLE) && (reg_rd || reg_wr);	// Busy drops it
	assign reg_hit  = strobe && !reg_addr[sel];
	assign reg_off  = {{(dw-sel){1'b0}}, reg_addr[sel-1:0]};
	assign deny_clr = reg_hit && reg_wr && (reg_off == policy_pkg::reg_deny_addr);

	always_comb begin
		case (reg_off)
			policy_pkg::reg_id_addr:   reg_rval = policy_pkg::block_id;
			policy_pkg::reg_ctrl_addr: reg_rval = {{(dw-1){1'b0}}, ctrl_en};
			policy_pkg::reg_deny_addr: reg_rval = deny_cnt;
			default:                   reg_rval = '0;	// Unmapped
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= policy_pkg::PIO_IDLE;
			ctrl_en  <= 1'b1;	// Lookups enabled out of reset
			deny_cnt <= '0;
		end else begin
			case (state)
				policy_pkg::PIO_IDLE: begin
					if (reg_hit)
						state <= policy_pkg::PIO_ACK;
					else if (strobe)
						state <= policy_pkg::PIO_MEM_ISSUE;
				end
				policy_pkg::PIO_MEM_ISSUE: state <= policy_pkg::PIO_MEM_WAIT;
				policy_pkg::PIO_MEM_WAIT: begin
					if (mem_ack)
						state <= policy_pkg::PIO_ACK;
				end
				default: state <= policy_pkg::PIO_IDLE;
			endcase
			if (reg_hit && reg_wr && (reg_off == policy_pkg::reg_ctrl_addr))
				ctrl_en <= reg_din[0];
			if (deny_clr)
				deny_cnt <= '0;	// Any write value clears
			else if (lookup_denied && (deny_cnt != '1))
				deny_cnt <= deny_cnt + 1'b1;
		end
	end

	// Captured access and read data
	always_ff @(posedge clk) begin
		if (strobe) begin
			addr_q <= reg_addr;
			din_q  <= reg_din;
			wr_q   <= reg_wr;
		end
		if (reg_hit)
			rdata_q <= reg_rval;
		else if ((state == policy_pkg::PIO_MEM_WAIT) && mem_ack)
			rdata_q <= mem_rdata;
	end

	assign mem_addr      = addr_q;
	assign mem_din       = din_q;
	assign mem_sel       = (state == policy_pkg::PIO_MEM_ISSUE);
	assign mem_rd        = mem_sel && !wr_q;
	assign mem_wr        = mem_sel && wr_q;
	assign reg_ack       = (state == policy_pkg::PIO_ACK);
	assign reg_rdata     = rdata_q;
	assign lookup_enable = ctrl_en;

endmodule

// File: logic/policy_lookup.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Policy lookup pipeline
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module policy_lookup #(
	parameter int depth_nbits = 6,
	parameter int item_nbits  = 16
) (
	input  logic                                          clk,
	input  logic                                          rst_n,

	// Request and result
	input  logic                                          lookup_req,
	input  logic [depth_nbits-1:0]                        lookup_tid,
	input  logic [policy_pkg::role_nbits-1:0]             lookup_role,
	input  policy_pkg::policy_op_t                        lookup_op,
	input  logic                                          lookup_enable,
	output logic                                          lookup_done,
	output logic [item_nbits-1:0]                         lookup_item,
	output logic                                          lookup_permit,
	output logic                                          lookup_denied,

	// Table read
	output logic                                          topic_policy_rd,
	output logic [depth_nbits-1:0]                        topic_policy_raddr,
	input  logic                                          topic_policy_ack,
	input  logic [item_nbits*policy_pkg::role_count-1:0]  topic_policy_rdata
);

	logic [policy_pkg::role_nbits-1:0] role_q;
	policy_pkg::policy_op_t            op_q;
	logic                              en_q;
	logic [item_nbits-1:0]             item;
	logic                              permit;

	// Read goes out in the request cycle
	assign topic_policy_rd    = lookup_req;
	assign topic_policy_raddr = lookup_tid;

	// Request fields travel beside the table read
	always_ff @(posedge clk) begin
		if (lookup_req) begin
			role_q <= lookup_role;
			op_q   <= lookup_op;
			en_q   <= lookup_enable;	// Enable sampled at request time
		end
	end

	assign item   = topic_policy_rdata[role_q*item_nbits +: item_nbits];
	assign permit = item[op_q] && en_q;

	always_ff @(posedge clk) begin
		if (topic_policy_ack) begin
			lookup_item   <= item;
			lookup_permit <= permit;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lookup_done   <= 1'b0;
			lookup_denied <= 1'b0;
		end else begin
			lookup_done   <= topic_policy_ack;
			lookup_denied <= topic_policy_ack && !permit;
		end
	end

endmodule

// File: logic/policy_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Topic policy table top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module policy_top #(
	parameter int depth_nbits = policy_pkg::def_depth_nbits,
	parameter int item_nbits  = policy_pkg::def_item_nbits
) (
	input  logic                              clk,
	input  logic                              rst_n,

	// Host bus
	input  logic [policy_pkg::pio_nbits-1:0]  reg_addr,
	input  logic [policy_pkg::pio_nbits-1:0]  reg_din,
	input  logic                              reg_rd,
	input  logic                              reg_wr,
	output logic                              reg_ack,
	output logic [policy_pkg::pio_nbits-1:0]  reg_rdata,

	// Lookup
	input  logic                              lookup_req,
	input  logic [depth_nbits-1:0]            lookup_tid,
	input  logic [policy_pkg::role_nbits-1:0] lookup_role,
	input  policy_pkg::policy_op_t            lookup_op,
	output logic                              lookup_done,
	output logic [item_nbits-1:0]             lookup_item,
	output logic                              lookup_permit
);

	localparam int value_nbits = item_nbits * policy_pkg::role_count;

	logic [policy_pkg::pio_nbits-1:0] mem_addr;
	logic [policy_pkg::pio_nbits-1:0] mem_din;
	logic                             mem_rd;
	logic                             mem_wr;
	logic                             mem_sel;
	logic                             mem_ack;
	logic [policy_pkg::pio_nbits-1:0] mem_rdata;
	logic                             topic_policy_rd;
	logic [depth_nbits-1:0]           topic_policy_raddr;
	logic                             topic_policy_ack;
	logic [value_nbits-1:0]           topic_policy_rdata;
	logic                             lookup_enable;
	logic                             lookup_denied;

	pio_ctrl u_pio_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.reg_ack       (reg_ack),
		.reg_rdata     (reg_rdata),
		.mem_addr      (mem_addr),
		.mem_din       (mem_din),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.mem_sel       (mem_sel),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.lookup_denied (lookup_denied),
		.lookup_enable (lookup_enable)
	);

	topic_policy_mem #(
		.depth_nbits (depth_nbits),
		.item_nbits  (item_nbits)
	) u_topic_policy_mem (
		.clk                (clk),
		.rst_n              (rst_n),
		.mem_addr           (mem_addr),
		.mem_din            (mem_din),
		.mem_rd             (mem_rd),
		.mem_wr             (mem_wr),
		.mem_sel            (mem_sel),
		.mem_ack            (mem_ack),
		.mem_rdata          (mem_rdata),
		.topic_policy_rd    (topic_policy_rd),
		.topic_policy_raddr (topic_policy_raddr),
		.topic_policy_ack   (topic_policy_ack),
		.topic_policy_rdata (topic_policy_rdata)
	);

	policy_lookup #(
		.depth_nbits (depth_nbits),
		.item_nbits  (item_nbits)
	) u_policy_lookup (
		.clk                (clk),
		.rst_n              (rst_n),
		.lookup_req         (lookup_req),
		.lookup_tid         (lookup_tid),
		.lookup_role        (lookup_role),
		.lookup_op          (lookup_op),
		.lookup_enable      (lookup_enable),
		.lookup_done        (lookup_done),
		.lookup_item        (lookup_item),
		.lookup_permit      (lookup_permit),
		.lookup_denied      (lookup_denied),
		.topic_policy_rd    (topic_policy_rd),
		.topic_policy_raddr (topic_policy_raddr),
		.topic_policy_ack   (topic_policy_ack),
		.topic_policy_rdata (topic_policy_rdata)
	);

endmodule

// File: verification/policy_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Topic policy table testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module policy_tb;

	localparam int depth_nbits = policy_pkg::def_depth_nbits;
	localparam int item_nbits  = policy_pkg::def_item_nbits;
	localparam int rows        = 1 << depth_nbits;
	localparam int banks       = policy_pkg::role_count;
	localparam int dw          = policy_pkg::pio_nbits;
	localparam int n_lookups   = 96;	// Enabled plus disabled runs
	localparam int n_host      = 2 * rows * banks + 16;
	localparam int wd_cycles   = n_host * 6 + (n_lookups + 10) * 2 + 200;

	logic                              clk;
	logic                              rst_n;
	logic [dw-1:0]                     reg_addr;
	logic [dw-1:0]                     reg_din;
	logic                              reg_rd;
	logic                              reg_wr;
	logic                              reg_ack;
	logic [dw-1:0]                     reg_rdata;
	logic                              lookup_req;
	logic [depth_nbits-1:0]            lookup_tid;
	logic [policy_pkg::role_nbits-1:0] lookup_role;
	policy_pkg::policy_op_t            lookup_op;
	logic                              lookup_done;
	logic [item_nbits-1:0]             lookup_item;
	logic                              lookup_permit;

	int                    seed = 81;
	logic [item_nbits-1:0] model_tbl [0:rows-1][0:banks-1];
	logic                  model_en = 1'b1;
	logic [dw-1:0]         model_deny = '0;
	logic [dw-1:0]         deny_base = '0;	// Model count at the last clear
	logic [dw-1:0]         exp_rdata = '0;
	logic                  chk_rdata = 1'b0;

	// Expected timing, tracked from the strobes the testbench drives
	logic                  reg_acc_d1 = 1'b0;
	logic                  tbl_acc_d1 = 1'b0;
	logic                  tbl_acc_d2 = 1'b0;
	logic                  tbl_acc_d3 = 1'b0;
	logic                  req_d1 = 1'b0;
	logic                  req_d2 = 1'b0;
	logic [item_nbits-1:0] item_d1;
	logic [item_nbits-1:0] item_d2;
	logic                  permit_d1;
	logic                  permit_d2;
	logic                  exp_ack;

	policy_top #(
		.depth_nbits (depth_nbits),
		.item_nbits  (item_nbits)
	) u_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.reg_addr      (reg_addr),
		.reg_din       (reg_din),
		.reg_rd        (reg_rd),
		.reg_wr        (reg_wr),
		.reg_ack       (reg_ack),
		.reg_rdata     (reg_rdata),
		.lookup_req    (lookup_req),
		.lookup_tid    (lookup_tid),
		.lookup_role   (lookup_role),
		.lookup_op     (lookup_op),
		.lookup_done   (lookup_done),
		.lookup_item   (lookup_item),
		.lookup_permit (lookup_permit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		reg_acc_d1 <= (reg_rd || reg_wr) && !reg_addr[policy_pkg::mem_sel_bit];
		tbl_acc_d1 <= (reg_rd || reg_wr) && reg_addr[policy_pkg::mem_sel_bit];
		tbl_acc_d2 <= tbl_acc_d1;
		tbl_acc_d3 <= tbl_acc_d2;
		req_d1     <= lookup_req;
		req_d2     <= req_d1;
		if (lookup_req) begin
			item_d1   <= model_tbl[lookup_tid][lookup_role];
			permit_d1 <= model_tbl[lookup_tid][lookup_role][lookup_op] && model_en;
		end
		item_d2   <= item_d1;
		permit_d2 <= permit_d1;
		if (req_d2 && !permit_d2)
			model_deny <= model_deny + 1;	// Denied result seen this cycle
	end

	assign exp_ack = reg_acc_d1 || tbl_acc_d3;	// Register region 1 cycle, table 3 cycles

	task automatic report_mismatch(input string sig, input logic [dw-1:0] exp,
		input logic [dw-1:0] act);
		$display("** Error at %0t ns: %s expected 0x%h, got 0x%h", $time, sig, exp, act);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first mismatch");
	endtask

	assert property (@(posedge clk) disable iff (!rst_n) reg_ack == exp_ack)
		else report_mismatch("reg_ack", dw'($sampled(exp_ack)), dw'($sampled(reg_ack)));
	assert property (@(posedge clk) disable iff (!rst_n)
		!(reg_ack && chk_rdata) || reg_rdata == exp_rdata)
		else report_mismatch("reg_rdata", $sampled(exp_rdata), $sampled(reg_rdata));
	assert property (@(posedge clk) disable iff (!rst_n) lookup_done == req_d2)
		else report_mismatch("lookup_done", dw'($sampled(req_d2)),
			dw'($sampled(lookup_done)));
	assert property (@(posedge clk) disable iff (!rst_n) !req_d2 || lookup_item == item_d2)
		else report_mismatch("lookup_item", dw'($sampled(item_d2)),
			dw'($sampled(lookup_item)));
	assert property (@(posedge clk) disable iff (!rst_n)
		!req_d2 || lookup_permit == permit_d2)
		else report_mismatch("lookup_permit", dw'($sampled(permit_d2)),
			dw'($sampled(lookup_permit)));

	function automatic logic [dw-1:0] tbl_addr(input int row, input int bank);
		logic [dw-1:0] a;
		a = '0;
		a[policy_pkg::mem_sel_bit] = 1'b1;
		a[4 +: depth_nbits]        = row[depth_nbits-1:0];
		a[3:2]                     = bank[1:0];
		return a;
	endfunction

	// One strobe, then wait for reg_ack
	task automatic issue_access(input logic wr, input logic [dw-1:0] addr,
		input logic [dw-1:0] data, input logic chk, input logic [dw-1:0] exp);
		@(posedge clk);
		reg_addr  <= addr;
		reg_din   <= data;
		reg_wr    <= wr;
		reg_rd    <= !wr;
		chk_rdata <= chk;
		exp_rdata <= exp;
		@(posedge clk);
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
		@(negedge clk);
		while (!reg_ack)
			@(negedge clk);
	endtask

	task automatic host_write(input logic [dw-1:0] addr, input logic [dw-1:0] data);
		issue_access(1'b1, addr, data, 1'b0, '0);
	endtask

	task automatic host_read(input logic [dw-1:0] addr, input logic [dw-1:0] exp);
		issue_access(1'b0, addr, dw'($random(seed)), 1'b1, exp);
	endtask

	// Back-to-back requests, one per cycle
	task automatic run_lookups(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			r = $random(seed);
			lookup_req  <= 1'b1;
			lookup_tid  <= r[depth_nbits-1:0];
			lookup_role <= r[9:8];
			lookup_op   <= policy_pkg::policy_op_t'(r[16]);
		end
		@(posedge clk);
		lookup_req <= 1'b0;
		@(negedge clk);
		while (req_d1 || req_d2 || lookup_done)
			@(negedge clk);
	endtask

	initial begin
		logic [31:0] r;
		logic [dw-1:0] exp;
		rst_n       = 1'b0;
		reg_addr    = '0;
		reg_din     = '0;
		reg_rd      = 1'b0;
		reg_wr      = 1'b0;
		lookup_req  = 1'b0;
		lookup_tid  = '0;
		lookup_role = '0;
		lookup_op   = policy_pkg::OP_PUBLISH;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		host_read(policy_pkg::reg_id_addr, policy_pkg::block_id);
		host_read(policy_pkg::reg_ctrl_addr, 32'h1);

		for (int row = 0; row < rows; row++) begin
			for (int bank = 0; bank < banks; bank++) begin
				r = $random(seed);	// Upper bits must be dropped
				model_tbl[row][bank] = r[item_nbits-1:0];
				host_write(tbl_addr(row, bank), r);
			end
		end
		for (int row = 0; row < rows; row++) begin
			for (int bank = 0; bank < banks; bank++) begin
				exp = '0;
				exp[item_nbits-1:0] = model_tbl[row][bank];
				host_read(tbl_addr(row, bank), exp);
			end
		end

		run_lookups(n_lookups / 2);
		host_read(policy_pkg::reg_deny_addr, model_deny - deny_base);

		host_write(policy_pkg::reg_ctrl_addr, 32'h0);
		model_en = 1'b0;
		host_read(policy_pkg::reg_ctrl_addr, 32'h0);
		run_lookups(n_lookups / 2);	// Every result denied
		host_read(policy_pkg::reg_deny_addr, model_deny - deny_base);

		host_write(policy_pkg::reg_deny_addr, 32'hA5A5_0001);	// Any value clears
		deny_base = model_deny;
		host_read(policy_pkg::reg_deny_addr, 32'h0);

		repeat (2) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

	initial begin
		#(wd_cycles * 100);
		$display("Watchdog expired before the tests completed");
		$display("Done: errors found");
		$fatal(1, "Simulation stopped by the watchdog");
	end

endmodule

// File: compile.f
logic/policy_pkg.sv
logic/pio_bank.sv
logic/topic_policy_mem.sv
logic/pio_ctrl.sv
logic/policy_lookup.sv
logic/policy_top.sv
verification/policy_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the policy table testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module policy_tb -o policy_sim &&
	./obj_dir/policy_sim ||
	exit 1
